//--- hw/isa_pkg.sv
package isa_pkg;

	////////////////////////////////////////
	// Data and register numbering
	////////////////////////////////////////

	typedef logic [15:0] word_t;
	typedef logic [3:0] reg_id_t;          // 0..7 general, 8 and up special

	localparam reg_id_t REG_SP = 4'd8;
	localparam reg_id_t REG_T = 4'd9;      // Compare result
	localparam reg_id_t REG_IH = 4'd10;
	localparam reg_id_t REG_NONE = 4'd15;  // No read, no write

	////////////////////////////////////////
	// Instruction encodings
	////////////////////////////////////////

	// Major opcode, bits 15..11
	typedef enum logic [4:0] {
		NOP = 5'b00001,
		GRP_SHIFT = 5'b00110,   // SLL, SRA
		ADDIU3 = 5'b01000,
		ADDIU = 5'b01001,
		GRP_SP = 5'b01100,      // ADDSP, MTSP
		LI = 5'b01101,
		CMPI = 5'b01110,
		GRP_RR = 5'b11100,      // ADDU, SUBU
		GRP_LOGIC = 5'b11101,   // AND, OR, CMP, SLT, SRAV, MFPC
		GRP_IH = 5'b11110       // MFIH, MTIH by bit 0
	} major_op_e;

	// GRP_SP, bits 10..8
	typedef enum logic [2:0] {
		SP_ADDSP = 3'b011,
		SP_MTSP = 3'b100
	} sub_sp_e;

	// GRP_RR, bits 1..0
	typedef enum logic [1:0] {
		RR_ADDU = 2'b01,
		RR_SUBU = 2'b11
	} sub_rr_e;

	// GRP_LOGIC, bits 4..0
	typedef enum logic [4:0] {
		LOGIC_PC = 5'b00000,    // MFPC when bits 7..5 match MFPC_RY
		LOGIC_SLT = 5'b00010,
		LOGIC_SRAV = 5'b00111,
		LOGIC_CMP = 5'b01010,
		LOGIC_AND = 5'b01100,
		LOGIC_OR = 5'b01101
	} sub_logic_e;

	localparam logic [2:0] MFPC_RY = 3'b010;

	// GRP_SHIFT, bits 1..0
	typedef enum logic [1:0] {
		SH_SLL = 2'b00,
		SH_SRA = 2'b11
	} sub_shift_e;

	////////////////////////////////////////
	// Execute controls
	////////////////////////////////////////

	typedef enum logic [3:0] {
		ALU_ADD = 4'b0000,
		ALU_AND = 4'b0001,
		ALU_OR = 4'b0010,
		ALU_SLL = 4'b0011,
		ALU_SRA = 4'b0101,
		ALU_SUB = 4'b0110,
		ALU_EQUAL = 4'b0111,    // 0 when equal
		ALU_LESS = 4'b1000,     // Signed
		ALU_MOVE = 4'b1001,
		ALU_NONE = 4'b1111
	} alu_op_e;

	typedef enum logic [1:0] {
		SRC_RR = 2'b00,         // A reg, B reg
		SRC_RI = 2'b01,         // A reg, B imm
		SRC_R = 2'b10,          // A reg only
		SRC_I = 2'b11           // Imm only
	} src_sel_e;

endpackage

//--- hw/core_pkg.sv
package core_pkg;

	// Fetched instruction into decode
	typedef struct packed {
		logic valid;
		isa_pkg::word_t pc;
		logic [15:0] instr;
	} instr_t;

	// Decode to execute
	typedef struct packed {
		logic valid;
		isa_pkg::alu_op_e alu_op;
		isa_pkg::src_sel_e src_sel;
		isa_pkg::reg_id_t reg_a;
		isa_pkg::reg_id_t reg_b;
		isa_pkg::word_t imm;
		logic wr_en;
		isa_pkg::reg_id_t wr_reg;
	} uop_t;

	// Execute to result stage
	typedef struct packed {
		logic valid;
		logic wr_en;
		isa_pkg::reg_id_t wr_reg;
		isa_pkg::word_t data;
	} exec_t;

	// Write-back report to the outside
	typedef struct packed {
		logic valid;
		isa_pkg::reg_id_t wr_reg;
		isa_pkg::word_t data;
	} wb_t;

endpackage

//--- hw/instr_decode.sv
`timescale 1ns/1ps

module instr_decode (
	input logic clk,
	input logic rst_n,
	input core_pkg::instr_t in_instr,
	output core_pkg::uop_t uop
);

	import isa_pkg::*;
	import core_pkg::*;

	logic [15:0] ins;
	reg_id_t rx;
	reg_id_t ry;
	reg_id_t rz;
	word_t simm8;
	word_t simm4;
	word_t zimm8;
	word_t shamt;
	uop_t dec;

	assign ins = in_instr.instr;
	assign rx = {1'b0, ins[10:8]};
	assign ry = {1'b0, ins[7:5]};
	assign rz = {1'b0, ins[4:2]};
	assign simm8 = {{8{ins[7]}}, ins[7:0]};
	assign simm4 = {{12{ins[3]}}, ins[3:0]};
	assign zimm8 = {8'd0, ins[7:0]};
	assign shamt = (ins[4:2] == 3'd0) ? 16'd8 : {13'd0, ins[4:2]}; // 0 means 8

	////////////////////////////////////////
	// Field decode
	////////////////////////////////////////

	always_comb begin
		dec.valid = in_instr.valid;
		dec.alu_op = ALU_NONE;      // Anything unmatched is a NOP
		dec.src_sel = SRC_I;
		dec.reg_a = REG_NONE;
		dec.reg_b = REG_NONE;
		dec.imm = '0;
		dec.wr_en = 1'b0;
		dec.wr_reg = REG_NONE;

		case (major_op_e'(ins[15:11]))
			ADDIU: begin
				dec = '{in_instr.valid, ALU_ADD, SRC_RI, rx, REG_NONE, simm8, 1'b1, rx};
			end
			ADDIU3: begin
				dec = '{in_instr.valid, ALU_ADD, SRC_RI, rx, REG_NONE, simm4, 1'b1, ry};
			end
			GRP_SP: begin
				case (sub_sp_e'(ins[10:8]))
					SP_ADDSP: begin
						dec.alu_op = ALU_ADD;
						dec.src_sel = SRC_RI;
						dec.reg_a = REG_SP;
						dec.imm = simm8;
						dec.wr_en = 1'b1;
						dec.wr_reg = REG_SP;
					end
					SP_MTSP: begin
						dec.alu_op = ALU_MOVE;
						dec.src_sel = SRC_R;
						dec.reg_a = ry;
						dec.wr_en = 1'b1;
						dec.wr_reg = REG_SP;
					end
					default: ;      // Branches on T dropped
				endcase
			end
			GRP_RR: begin
				case (sub_rr_e'(ins[1:0]))
					RR_ADDU, RR_SUBU: begin
						dec.alu_op = (ins[1]) ? ALU_SUB : ALU_ADD;
						dec.src_sel = SRC_RR;
						dec.reg_a = rx;
						dec.reg_b = ry;
						dec.wr_en = 1'b1;
						dec.wr_reg = rz;
					end
					default: ;
				endcase
			end
			GRP_LOGIC: begin
				dec.src_sel = SRC_RR;
				dec.reg_a = rx;
				dec.reg_b = ry;
				case (sub_logic_e'(ins[4:0]))
					LOGIC_AND: dec.alu_op = ALU_AND;
					LOGIC_OR: dec.alu_op = ALU_OR;
					LOGIC_CMP: dec.alu_op = ALU_EQUAL;
					LOGIC_SLT: dec.alu_op = ALU_LESS;
					LOGIC_SRAV: begin
						dec.alu_op = ALU_SRA;
						dec.reg_a = ry;     // Value in ry, count in rx
						dec.reg_b = rx;
					end
					LOGIC_PC: begin
						if (ins[7:5] == MFPC_RY) begin
							dec.alu_op = ALU_MOVE;
							dec.src_sel = SRC_I;
							dec.reg_a = REG_NONE;
							dec.reg_b = REG_NONE;
							dec.imm = in_instr.pc;
						end
					end
					default: ;
				endcase
				dec.wr_en = (dec.alu_op != ALU_NONE);
				case (dec.alu_op)
					ALU_EQUAL, ALU_LESS: dec.wr_reg = REG_T;
					ALU_SRA: dec.wr_reg = ry;
					ALU_NONE: dec.wr_reg = REG_NONE;
					default: dec.wr_reg = rx;
				endcase
			end
			LI: begin
				dec = '{in_instr.valid, ALU_MOVE, SRC_I, REG_NONE, REG_NONE, zimm8, 1'b1, rx};
			end
			GRP_IH: begin
				dec.alu_op = ALU_MOVE;
				dec.src_sel = SRC_R;
				dec.wr_en = 1'b1;
				if (ins[0]) begin   // MTIH
					dec.reg_a = rx;
					dec.wr_reg = REG_IH;
				end else begin      // MFIH
					dec.reg_a = REG_IH;
					dec.wr_reg = rx;
				end
			end
			GRP_SHIFT: begin
				case (sub_shift_e'(ins[1:0]))
					SH_SLL, SH_SRA: begin
						dec.alu_op = (ins[0]) ? ALU_SRA : ALU_SLL;
						dec.src_sel = SRC_RI;
						dec.reg_a = ry;
						dec.imm = shamt;
						dec.wr_en = 1'b1;
						dec.wr_reg = rx;
					end
					default: ;
				endcase
			end
			CMPI: begin
				dec = '{in_instr.valid, ALU_EQUAL, SRC_RI, rx, REG_NONE, simm8, 1'b1, REG_T};
			end
			default: ;              // NOP, memory, jumps
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			uop.valid <= 1'b0;
			uop.wr_en <= 1'b0;
		end else begin
			uop <= dec;
		end
	end

endmodule

//--- hw/alu_execute.sv
`timescale 1ns/1ps

module alu_execute (
	input logic clk,
	input logic rst_n,
	input core_pkg::uop_t uop,
	output isa_pkg::reg_id_t rd_addr_a,
	output isa_pkg::reg_id_t rd_addr_b,
	input isa_pkg::word_t rd_data_a,
	input isa_pkg::word_t rd_data_b,
	output core_pkg::exec_t result
);

	import isa_pkg::*;

	logic fwd_a;
	logic fwd_b;
	word_t reg_a_val;
	word_t reg_b_val;
	word_t opnd_a;
	word_t opnd_b;
	word_t alu_out;

	assign rd_addr_a = uop.reg_a;
	assign rd_addr_b = uop.reg_b;

	////////////////////////////////////////
	// Bypass and operand select
	////////////////////////////////////////

	// Previous instruction still sits in the result register
	assign fwd_a = result.valid && result.wr_en && (result.wr_reg == uop.reg_a);
	assign fwd_b = result.valid && result.wr_en && (result.wr_reg == uop.reg_b);

	assign reg_a_val = fwd_a ? result.data : rd_data_a;
	assign reg_b_val = fwd_b ? result.data : rd_data_b;

	assign opnd_a = (uop.src_sel == SRC_I) ? uop.imm : reg_a_val;
	assign opnd_b = (uop.src_sel == SRC_RR) ? reg_b_val : uop.imm;

	////////////////////////////////////////
	// ALU
	////////////////////////////////////////

	always_comb begin
		case (uop.alu_op)
			ALU_ADD: alu_out = opnd_a + opnd_b;     // Wraps at 16 bits
			ALU_SUB: alu_out = opnd_a - opnd_b;
			ALU_AND: alu_out = opnd_a & opnd_b;
			ALU_OR: alu_out = opnd_a | opnd_b;
			ALU_SLL: alu_out = opnd_a << opnd_b[3:0];
			ALU_SRA: alu_out = $signed(opnd_a) >>> opnd_b[3:0];
			ALU_EQUAL: alu_out = {15'd0, opnd_a != opnd_b};
			ALU_LESS: alu_out = {15'd0, $signed(opnd_a) < $signed(opnd_b)};
			ALU_MOVE: alu_out = opnd_a;     // Reg for SRC_R, imm for SRC_I
			default: alu_out = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			result.valid <= 1'b0;
			result.wr_en <= 1'b0;
		end else begin
			result.valid <= uop.valid;
			result.wr_en <= uop.valid && uop.wr_en;
		end
		result.wr_reg <= uop.wr_reg;
		result.data <= alu_out;
	end

endmodule

//--- hw/reg_writeback.sv
`timescale 1ns/1ps

module reg_writeback (
	input logic clk,
	input logic rst_n,
	input isa_pkg::reg_id_t rd_addr_a,
	input isa_pkg::reg_id_t rd_addr_b,
	output isa_pkg::word_t rd_data_a,
	output isa_pkg::word_t rd_data_b,
	input core_pkg::exec_t result,
	output core_pkg::wb_t wb
);

	import isa_pkg::*;

	word_t regs [16];
	logic wr_fire;

	assign wr_fire = result.valid && result.wr_en && (result.wr_reg != REG_NONE);

	// Same-edge write is covered by the execute bypass
	assign rd_data_a = regs[rd_addr_a];
	assign rd_data_b = regs[rd_addr_b];

	////////////////////////////////////////
	// Register file
	////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < 16; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_fire) begin
			regs[result.wr_reg] <= result.data;
		end
	end

	////////////////////////////////////////
	// Write-back report
	////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wb.valid <= 1'b0;
		end else begin
			wb.valid <= wr_fire;    // Only writers report
		end
		wb.wr_reg <= result.wr_reg;
		wb.data <= result.data;
	end

endmodule

//--- hw/alu_core.sv
`timescale 1ns/1ps

module alu_core (
	input logic clk,
	input logic rst_n,
	input core_pkg::instr_t in_instr,
	output core_pkg::wb_t out_wb
);

	import isa_pkg::*;
	import core_pkg::*;

	uop_t uop;
	exec_t result;
	reg_id_t rd_addr_a;
	reg_id_t rd_addr_b;
	word_t rd_data_a;
	word_t rd_data_b;

	instr_decode u_decode (
		.clk(clk),
		.rst_n(rst_n),
		.in_instr(in_instr),
		.uop(uop)
	);

	alu_execute u_execute (
		.clk(clk),
		.rst_n(rst_n),
		.uop(uop),
		.rd_addr_a(rd_addr_a),
		.rd_addr_b(rd_addr_b),
		.rd_data_a(rd_data_a),
		.rd_data_b(rd_data_b),
		.result(result)
	);

	reg_writeback u_writeback (
		.clk(clk),
		.rst_n(rst_n),
		.rd_addr_a(rd_addr_a),
		.rd_addr_b(rd_addr_b),
		.rd_data_a(rd_data_a),
		.rd_data_b(rd_data_b),
		.result(result),
		.wb(out_wb)
	);

endmodule

//--- dv/clk_gen.sv
`timescale 1ns/1ps

module clk_gen (
	output logic clk
);

	localparam time HALF_PERIOD = 50ns;    // 100 ns period

	initial begin
		clk = 1'b0;
	end

	always #(HALF_PERIOD) clk = ~clk;

endmodule

//--- dv/core_tb_vectors.svh
task automatic load_vectors();
	// instr, pc, expect write, expected wr_reg, expected data
	add_row(16'h697F, 16'h0100, 1'b1, 4'd1, 16'h007F);     // LI r1, 0x7F
	add_row(16'h6A85, 16'h0101, 1'b1, 4'd2, 16'h0085);     // LI r2, 0x85
	add_row(16'h6BF0, 16'h0102, 1'b1, 4'd3, 16'h00F0);     // LI r3, 0xF0
	add_row(16'hE151, 16'h0103, 1'b1, 4'd4, 16'h0104);     // ADDU r4 = r1 + r2
	add_row(16'hE477, 16'h0104, 1'b1, 4'd5, 16'h0014);     // SUBU r5 = r4 - r3
	add_row(16'hE59B, 16'h0105, 1'b1, 4'd6, 16'hFF10);     // SUBU r6 = r5 - r4, wraps
	add_row(16'hEE6C, 16'h0106, 1'b1, 4'd6, 16'h0010);     // AND r6, r3
	add_row(16'hEE4D, 16'h0107, 1'b1, 4'd6, 16'h0095);     // OR r6, r2
	add_row(16'h6FFF, 16'h0108, 1'b1, 4'd7, 16'h00FF);     // LI r7, 0xFF
	add_row(16'h4980, 16'h0109, 1'b1, 4'd1, 16'hFFFF);     // ADDIU r1, -128
	add_row(16'h414E, 16'h010A, 1'b1, 4'd2, 16'hFFFD);     // ADDIU3 r2 = r1 - 2
	add_row(16'h63FC, 16'h010B, 1'b1, 4'd8, 16'hFFFC);     // ADDSP -4
	add_row(16'h72FD, 16'h010C, 1'b1, 4'd9, 16'h0000);     // CMPI r2, -3 equal
	add_row(16'h7203, 16'h010D, 1'b1, 4'd9, 16'h0001);     // CMPI r2, 3
	add_row(16'h6BFD, 16'h010E, 1'b1, 4'd3, 16'h00FD);     // LI r3, 0xFD zero-extends
	add_row(16'h73FD, 16'h010F, 1'b1, 4'd9, 16'h0001);     // CMPI r3, -3
	add_row(16'h3460, 16'h0110, 1'b1, 4'd4, 16'hFD00);     // SLL r4 = r3 << 8
	add_row(16'h3583, 16'h0111, 1'b1, 4'd5, 16'hFFFD);     // SRA r5 = r4 >>> 8
	add_row(16'h358F, 16'h0112, 1'b1, 4'd5, 16'hFFA0);     // SRA r5 = r4 >>> 3
	add_row(16'h362C, 16'h0113, 1'b1, 4'd6, 16'hFFF8);     // SLL r6 = r1 << 3
	add_row(16'h6F04, 16'h0114, 1'b1, 4'd7, 16'h0004);     // LI r7, 4
	add_row(16'hEF87, 16'h0115, 1'b1, 4'd4, 16'hFFD0);     // SRAV r4 >>>= r7
	add_row(16'hE621, 16'h0116, 1'b1, 4'd0, 16'hFFF7);     // ADDU r0 = r6 + r1, wraps
	add_row(16'hE80A, 16'h0117, 1'b1, 4'd9, 16'h0000);     // CMP r0, r0
	add_row(16'hED8A, 16'h0118, 1'b1, 4'd9, 16'h0001);     // CMP r5, r4
	add_row(16'hED82, 16'h0119, 1'b1, 4'd9, 16'h0001);     // SLT r5, r4
	add_row(16'hECA2, 16'h011A, 1'b1, 4'd9, 16'h0000);     // SLT r4, r5
	add_row(16'hEBA2, 16'h011B, 1'b1, 4'd9, 16'h0000);     // SLT r3, r5 signed
	add_row(16'hED62, 16'h011C, 1'b1, 4'd9, 16'h0001);     // SLT r5, r3 signed
	add_row(16'h6460, 16'h011D, 1'b1, 4'd8, 16'h00FD);     // MTSP r3
	add_row(16'h6303, 16'h011E, 1'b1, 4'd8, 16'h0100);     // ADDSP 3
	add_row(16'hF501, 16'h011F, 1'b1, 4'd10, 16'hFFA0);    // MTIH r5
	add_row(16'hF100, 16'h0120, 1'b1, 4'd1, 16'hFFA0);     // MFIH r1
	add_row(16'hEA40, 16'h0121, 1'b1, 4'd2, 16'h0121);     // MFPC r2
	add_row(16'h0800, 16'h0122, 1'b0, 4'd15, 16'h0000);    // NOP
	add_row(16'h9A20, 16'h0123, 1'b0, 4'd15, 16'h0000);    // LW, dropped
	add_row(16'h1005, 16'h0124, 1'b0, 4'd15, 16'h0000);    // B, dropped
	add_row(16'h6002, 16'h0125, 1'b0, 4'd15, 16'h0000);    // BTEQZ, dropped
	add_row(16'h4910, 16'h0126, 1'b1, 4'd1, 16'hFFB0);     // ADDIU r1, 0x10
	add_row(16'hE14D, 16'h0127, 1'b1, 4'd3, 16'h00D1);     // ADDU r3 = r1 + r2, wraps
	add_row(16'h0800, 16'h0128, 1'b0, 4'd15, 16'h0000);    // NOP
endtask

//--- dv/core_tb.sv
`timescale 1ns/1ps

module core_tb;

	import isa_pkg::*;
	import core_pkg::*;

	localparam int TIMEOUT_CYCLES = 20;
	localparam int QUIET_CYCLES = 10;
	localparam int LATENCY = 3;    // Falling edges from drive to report

	typedef struct packed {
		logic [15:0] instr;
		word_t pc;
		logic exp_wr;
		reg_id_t exp_reg;
		word_t exp_data;
	} row_t;

	logic clk;
	logic rst_n;
	instr_t in_instr;
	wb_t out_wb;
	row_t vectors [$];
	int error_count;
	int test_count;
	int pass_count;

	clk_gen u_clk_gen (
		.clk(clk)
	);

	alu_core u_dut (
		.clk(clk),
		.rst_n(rst_n),
		.in_instr(in_instr),
		.out_wb(out_wb)
	);

	task automatic add_row(input logic [15:0] instr, input word_t pc, input logic exp_wr,
			input reg_id_t exp_reg, input word_t exp_data);
		row_t row;
		row = '{instr, pc, exp_wr, exp_reg, exp_data};
		vectors.push_back(row);
	endtask

	`include "core_tb_vectors.svh"

	////////////////////////////////////////
	// Compare tasks
	////////////////////////////////////////

	task automatic check_reg(input string name, input reg_id_t expected, input reg_id_t actual,
			output bit ok);
		ok = (actual === expected);
		if (!ok) begin
			error_count++;
			$display("CHECK FAILED at %0t: %s expected %0d, got %0d", $time, name, expected, actual);
		end
	endtask

	task automatic check_word(input string name, input word_t expected, input word_t actual,
			output bit ok);
		ok = (actual === expected);
		if (!ok) begin
			error_count++;
			$display("CHECK FAILED at %0t: %s expected %h, got %h", $time, name, expected, actual);
		end
	endtask

	////////////////////////////////////////
	// Stimulus and collector
	////////////////////////////////////////

	task automatic drive_rows();
		foreach (vectors[i]) begin
			@(negedge clk);
			in_instr.valid = 1'b1;
			in_instr.pc = vectors[i].pc;
			in_instr.instr = vectors[i].instr;
		end
		@(negedge clk);
		in_instr = '0;
	endtask

	task automatic collect_reports();
		int waited;
		bit got;
		bit ok_reg;
		bit ok_data;
		foreach (vectors[i]) begin
			if (vectors[i].exp_wr) begin
				waited = 0;
				got = 1'b0;
				while (!got && waited < TIMEOUT_CYCLES) begin
					@(negedge clk);
					if (out_wb.valid === 1'b1) got = 1'b1;
					else waited++;
				end
				test_count++;
				if (!got) begin
					error_count++;
					$display("row %0d: no write-back report within %0d cycles", i, TIMEOUT_CYCLES);
					return;    // Pairing is lost from here on
				end
				check_reg("out_wb.wr_reg", vectors[i].exp_reg, out_wb.wr_reg, ok_reg);
				check_word("out_wb.data", vectors[i].exp_data, out_wb.data, ok_data);
				if (ok_reg && ok_data) pass_count++;
				$display("row %0d instr %h: %s", i, vectors[i].instr,
					(ok_reg && ok_data) ? "ok" : "mismatch");
			end
		end
	endtask

	task automatic check_quiet();
		bit quiet;
		quiet = 1'b1;
		repeat (QUIET_CYCLES) begin
			@(negedge clk);
			if (out_wb.valid !== 1'b0) quiet = 1'b0;
		end
		test_count++;
		if (quiet) begin
			pass_count++;
			$display("quiet window: ok");
		end else begin
			error_count++;
			$display("quiet window: a write-back report came after the last expected one");
		end
	endtask

	task automatic check_latency();
		int cycles;
		bit got;
		bit ok_reg;
		bit ok_data;
		@(negedge clk);
		in_instr = '{1'b1, 16'h0200, 16'h6C5A};    // LI r4, 0x5A
		cycles = 0;
		got = 1'b0;
		while (!got && cycles < TIMEOUT_CYCLES) begin
			@(negedge clk);
			cycles++;
			if (cycles == 1) in_instr.valid = 1'b0;
			if (out_wb.valid === 1'b1) got = 1'b1;
		end
		test_count++;
		if (!got) begin
			error_count++;
			$display("latency: no write-back report within %0d cycles", TIMEOUT_CYCLES);
			return;
		end
		check_reg("out_wb.wr_reg", 4'd4, out_wb.wr_reg, ok_reg);
		check_word("out_wb.data", 16'h005A, out_wb.data, ok_data);
		if (cycles != LATENCY) begin
			error_count++;
			$display("latency: report came after %0d cycles instead of %0d", cycles, LATENCY);
		end else if (ok_reg && ok_data) begin
			pass_count++;
		end
		$display("latency: %0d cycles, %s", cycles,
			(cycles == LATENCY && ok_reg && ok_data) ? "ok" : "mismatch");
	endtask

	initial begin
		error_count = 0;
		test_count = 0;
		pass_count = 0;
		rst_n = 1'b0;
		in_instr = '0;
		load_vectors();
		repeat (3) @(negedge clk);
		rst_n = 1'b1;
		fork
			drive_rows();
			collect_reports();
		join
		check_quiet();
		check_latency();
		$display("tests: %0d, passed: %0d, errors: %0d", test_count, pass_count, error_count);
		if (error_count == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

//--- filelist.f
+incdir+dv
hw/isa_pkg.sv
hw/core_pkg.sv
hw/instr_decode.sv
hw/alu_execute.sv
hw/reg_writeback.sv
hw/alu_core.sv
dv/clk_gen.sv
dv/core_tb.sv
